// File: filelist.f
+incdir+common
common/mem_bus_pkg.sv
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_regs.sv
logic/uart_periph.sv
sim/tb_uart_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build the UART peripheral testbench with Verilator, run it, then search the log
verilator --binary --timing --assert -f filelist.f --top-module tb_uart_periph \
    && ./obj_dir/Vtb_uart_periph > sim.log 2>&1 \
    || { echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// File: sim/tb_uart_periph.sv
/*
 * UART peripheral testbench
 * Table of bus and serial line operations applied in a loop, with a txd decoder,
 * an rxd frame generator and a watchdog
 */
`timescale 1ns/1ps
`include "uart_defines.svh"

module tb_uart_periph;

    // Test operations
    typedef enum logic [2:0] {
        OP_PINS,
        OP_READ,
        OP_WRITE,
        OP_TX_PAIR,
        OP_RX_FRAME,
        OP_RX_BAD,
        OP_OUTSIDE
    } op_e;

    // One table row, ser is the second TX byte or the byte sent on rxd
    typedef struct packed {
        op_e                     op;
        mem_bus_pkg::uart_reg_e  off;
        logic [31:0]             wdata;
        logic [3:0]              wstrb;
        logic [7:0]              ser;
        logic [31:0]             exp_data;
        logic                    exp_irq;
    } test_entry_t;

    localparam int NUM_TESTS = 16;
    // Matching request answers within two sampled cycles
    localparam int BUS_LIMIT = 8;
    localparam int OUTSIDE_LIMIT = 4;

    logic                  clk;
    logic                  rst_n;
    logic                  rxd;
    logic                  txd;
    logic                  irq_rx_valid;
    mem_bus_pkg::mem_req_t mem_req;
    mem_bus_pkg::mem_rsp_t mem_rsp;

    test_entry_t tests [NUM_TESTS];
    logic [7:0]  rnd [6];
    logic [15:0] prescale_model;
    int          check_errors = 0;
    int          passed_tests = 0;
    int          failed_tests = 0;
    int          watchdog_cycles = 0;

    // TX pair results, shared by the fork branches
    int          frames_done;
    int          frames_at_ack;
    logic        wr_ready_a;
    logic        wr_ready_b;
    logic [31:0] wr_rdata;
    logic        tx_ok_a;
    logic        tx_ok_b;
    logic [7:0]  tx_seen_a;
    logic [7:0]  tx_seen_b;

    uart_periph DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .rxd          (rxd),
        .txd          (txd),
        .irq_rx_valid (irq_rx_valid),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic test_entry_t make_entry(input op_e op, input mem_bus_pkg::uart_reg_e off,
            input logic [31:0] wdata, input logic [3:0] wstrb, input logic [7:0] ser,
            input logic [31:0] exp_data, input logic exp_irq);
        test_entry_t e;
        e = '{op: op, off: off, wdata: wdata, wstrb: wstrb, ser: ser,
              exp_data: exp_data, exp_irq: exp_irq};
        return e;
    endfunction

    // Word address inside the UART window
    function automatic logic [31:0] reg_addr(input mem_bus_pkg::uart_reg_e off);
        return {`UART_BASE_ADDR, 8'h00, 12'h000, off};
    endfunction

    function automatic int cycles_per_bit();
        return int'(prescale_model) * 8;
    endfunction

    // Hold the request until ready or the limit, sampling on falling edges
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
            input logic [3:0] wstrb, input int limit,
            output logic got_ready, output logic [31:0] rdata);
        int waited;
        waited = 0;
        got_ready = 1'b0;
        rdata = 32'h0;
        @(posedge clk);
        mem_req <= '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
        while (!got_ready && waited < limit) begin
            @(negedge clk);
            waited++;
            if (mem_rsp.ready) begin
                got_ready = 1'b1;
                rdata = mem_rsp.rdata;
            end
        end
        @(posedge clk);
        mem_req <= '0;
    endtask

    // Line model, decode one txd frame, LSB first
    task automatic decode_tx_frame(input int bit_cyc, input int limit,
            output logic ok, output logic [7:0] data);
        int waited;
        waited = 0;
        ok = 1'b0;
        data = 8'h00;
        @(negedge clk);
        while (txd !== 1'b0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (txd !== 1'b0) return;
        // Middle of the start bit
        repeat (bit_cyc / 2) @(negedge clk);
        if (txd !== 1'b0) return;
        repeat (8) begin
            repeat (bit_cyc) @(negedge clk);
            data = {txd, data[7:1]};
        end
        repeat (bit_cyc) @(negedge clk);
        ok = (txd === 1'b1);
    endtask

    // Line model, drive one frame on rxd then two idle bit times
    task automatic send_rx_frame(input logic [7:0] data, input logic stop_bit,
            input int bit_cyc);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        repeat (10) begin
            @(posedge clk);
            rxd <= frame[0];
            frame = frame >> 1;
            repeat (bit_cyc - 1) @(posedge clk);
        end
        @(posedge clk);
        rxd <= 1'b1;
        repeat (2 * bit_cyc) @(posedge clk);
    endtask

    // Two TX writes, the second one issued while the first frame is on the line
    task automatic run_tx_pair(input logic [7:0] first, input logic [7:0] second);
        int bit_cyc;
        bit_cyc = cycles_per_bit();
        frames_done = 0;
        fork
            begin
                bus_access(reg_addr(mem_bus_pkg::REG_TX), {24'h0, first}, 4'h1,
                           BUS_LIMIT, wr_ready_a, wr_rdata);
                bus_access(reg_addr(mem_bus_pkg::REG_TX), {24'h0, second}, 4'h1,
                           10 * bit_cyc + BUS_LIMIT, wr_ready_b, wr_rdata);
                frames_at_ack = frames_done;
            end
            begin
                decode_tx_frame(bit_cyc, 12 * bit_cyc, tx_ok_a, tx_seen_a);
                frames_done++;
                decode_tx_frame(bit_cyc, 12 * bit_cyc, tx_ok_b, tx_seen_b);
                frames_done++;
            end
        join
        assert (wr_ready_a && wr_ready_b) else begin
            $display("A write to the TX register was never acknowledged");
            check_errors++;
        end
        assert (frames_at_ack == 1) else begin
            $display("Second TX write was acknowledged before the first frame ended");
            check_errors++;
        end
        assert (tx_ok_a && tx_ok_b) else begin
            $display("A txd frame was missing or had a bad start or stop bit");
            check_errors++;
        end
        assert (tx_seen_a == first && tx_seen_b == second) else begin
            $display("Mismatch at %0t: txd bytes %h %h, expected %h %h",
                     $time, tx_seen_a, tx_seen_b, first, second);
            check_errors++;
        end
    endtask

    // ------------------------------
    // One table row
    // ------------------------------
    task automatic run_test(input int idx, input test_entry_t t);
        logic        got_ready;
        logic [31:0] rdata;
        int          errs_before;
        op_e         op;
        errs_before = check_errors;
        op = t.op;
        case (op)
            OP_PINS: begin
                assert (txd === 1'b1) else begin
                    $display("Mismatch at %0t: txd idle level %b, expected 1", $time, txd);
                    check_errors++;
                end
            end
            OP_READ, OP_WRITE: begin
                bus_access(reg_addr(t.off), t.wdata, t.wstrb, BUS_LIMIT, got_ready, rdata);
                assert (got_ready) else begin
                    $display("Test %0d: no ready for offset %h", idx, t.off);
                    check_errors++;
                end
                if (op == OP_READ) begin
                    assert (rdata == t.exp_data) else begin
                        $display("Mismatch at %0t: offset %h read %h, expected %h",
                                 $time, t.off, rdata, t.exp_data);
                        check_errors++;
                    end
                end else if (t.off == mem_bus_pkg::REG_BAUD) begin
                    // Strobes pick the prescale bytes
                    if (t.wstrb[0]) prescale_model[7:0] = t.wdata[7:0];
                    if (t.wstrb[1]) prescale_model[15:8] = t.wdata[15:8];
                end
            end
            OP_TX_PAIR: run_tx_pair(t.wdata[7:0], t.ser);
            OP_RX_FRAME: send_rx_frame(t.ser, 1'b1, cycles_per_bit());
            OP_RX_BAD: send_rx_frame(t.ser, 1'b0, cycles_per_bit());
            default: begin
                // Bits 23..16 nonzero, outside the window
                bus_access({`UART_BASE_ADDR, 8'h01, 12'h000, t.off}, 32'h0, 4'h0,
                           OUTSIDE_LIMIT, got_ready, rdata);
                assert (!got_ready) else begin
                    $display("Test %0d: request outside the window was acknowledged", idx);
                    check_errors++;
                end
            end
        endcase
        // Interrupt level after the operation has settled
        @(negedge clk);
        assert (irq_rx_valid === t.exp_irq) else begin
            $display("Mismatch at %0t: irq_rx_valid %b, expected %b",
                     $time, irq_rx_valid, t.exp_irq);
            check_errors++;
        end
        if (check_errors == errs_before) begin
            passed_tests++;
            $display("Test %0d %s passed", idx, op.name());
        end else begin
            failed_tests++;
            $display("Test %0d %s failed", idx, op.name());
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int frames;
        int max_prescale;
        void'($urandom(65903));
        rst_n = 1'b0;
        rxd = 1'b1;
        mem_req = '0;
        prescale_model = `UART_PRESCALE_RESET;
        for (int i = 0; i < 6; i++) begin
            rnd[i] = 8'($urandom());
        end

        // Reset state, then TX, RX, overrun, frame error and window checks
        tests[0] = make_entry(OP_PINS, mem_bus_pkg::REG_TX, 32'h0, 4'h0, 8'h00, 32'h0, 1'b0);
        tests[1] = make_entry(OP_READ, mem_bus_pkg::REG_STATUS, 32'h0, 4'h0, 8'h00, 32'h0, 1'b0);
        tests[2] = make_entry(OP_READ, mem_bus_pkg::REG_RX, 32'h0, 4'h0, 8'h00,
                              `UART_RX_EMPTY, 1'b0);
        tests[3] = make_entry(OP_WRITE, mem_bus_pkg::REG_BAUD, 32'h2, 4'h3, 8'h00, 32'h0, 1'b0);
        tests[4] = make_entry(OP_TX_PAIR, mem_bus_pkg::REG_TX, {24'h0, rnd[0]}, 4'h1, rnd[1],
                              32'h0, 1'b0);
        tests[5] = make_entry(OP_RX_FRAME, mem_bus_pkg::REG_RX, 32'h0, 4'h0, rnd[2], 32'h0, 1'b1);
        tests[6] = make_entry(OP_READ, mem_bus_pkg::REG_RX, 32'h0, 4'h0, 8'h00,
                              {24'h0, rnd[2]}, 1'b0);
        tests[7] = make_entry(OP_RX_FRAME, mem_bus_pkg::REG_RX, 32'h0, 4'h0, rnd[3], 32'h0, 1'b1);
        tests[8] = make_entry(OP_RX_FRAME, mem_bus_pkg::REG_RX, 32'h0, 4'h0, rnd[4], 32'h0, 1'b1);
        // Overrun is status bit 2, frame error bit 3
        tests[9] = make_entry(OP_READ, mem_bus_pkg::REG_STATUS, 32'h0, 4'h0, 8'h00,
                              32'h4, 1'b1);
        tests[10] = make_entry(OP_READ, mem_bus_pkg::REG_STATUS, 32'h0, 4'h0, 8'h00,
                               32'h0, 1'b1);
        tests[11] = make_entry(OP_READ, mem_bus_pkg::REG_RX, 32'h0, 4'h0, 8'h00,
                               {24'h0, rnd[4]}, 1'b0);
        tests[12] = make_entry(OP_RX_BAD, mem_bus_pkg::REG_RX, 32'h0, 4'h0, rnd[5], 32'h0, 1'b0);
        tests[13] = make_entry(OP_READ, mem_bus_pkg::REG_STATUS, 32'h0, 4'h0, 8'h00,
                               32'h8, 1'b0);
        tests[14] = make_entry(OP_READ, mem_bus_pkg::REG_STATUS, 32'h0, 4'h0, 8'h00,
                               32'h0, 1'b0);
        tests[15] = make_entry(OP_OUTSIDE, mem_bus_pkg::REG_STATUS, 32'h0, 4'h0, 8'h00,
                               32'h0, 1'b0);

        // Watchdog budget, 80 x prescale cycles per frame plus a margin
        frames = 0;
        max_prescale = int'(prescale_model);
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tests[i].op == OP_TX_PAIR) frames += 2;
            if (tests[i].op == OP_RX_FRAME || tests[i].op == OP_RX_BAD) frames += 1;
            if (tests[i].op == OP_WRITE && tests[i].off == mem_bus_pkg::REG_BAUD
                    && int'(tests[i].wdata[15:0]) > max_prescale) begin
                max_prescale = int'(tests[i].wdata[15:0]);
            end
        end
        watchdog_cycles = frames * 80 * max_prescale + 2000;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i, tests[i]);
        end

        $display("Tests %0d, passed %0d, failed %0d, check errors %0d",
                 NUM_TESTS, passed_tests, failed_tests, check_errors);
        if (failed_tests == 0 && check_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Ends a stuck run
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: logic/uart_periph.sv
/*
 * UART peripheral top level
 * Joins the memory bus, the register block and the TX and RX engines
 */
`timescale 1ns/1ps

module uart_periph (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rxd,
    output logic                   txd,
    output logic                   irq_rx_valid,
    input  mem_bus_pkg::mem_req_t  mem_req,
    output mem_bus_pkg::mem_rsp_t  mem_rsp
);

    logic [15:0]            prescale;
    logic [7:0]             tx_data;
    logic                   tx_valid;
    logic                   tx_ready;
    logic                   tx_busy;
    logic [7:0]             rx_data;
    logic                   rx_valid;
    logic                   rx_ack;
    logic                   rx_busy;
    logic                   clear_errors;
    logic                   overrun;
    logic                   frame_err;
    uart_pkg::uart_status_t status;

    // Status word from the engine flags
    assign status = '{frame_err: frame_err, overrun: overrun,
                      rx_busy: rx_busy, tx_busy: tx_busy};

    // Interrupt follows the RX valid level
    assign irq_rx_valid = rx_valid;

    uart_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .prescale     (prescale),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_ack       (rx_ack),
        .clear_errors (clear_errors),
        .status       (status)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .prescale (prescale),
        .txd      (txd),
        .busy     (tx_busy)
    );

    uart_rx u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rxd          (rxd),
        .prescale     (prescale),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_ack       (rx_ack),
        .clear_errors (clear_errors),
        .busy         (rx_busy),
        .overrun      (overrun),
        .frame_err    (frame_err)
    );

endmodule

// File: uart/uart_regs.sv
/*
 * UART register block
 * Decodes the bus window, serves TX, status, RX and baud registers
 * A TX write stalls the bus while the transmitter is busy
 */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_bus_pkg::mem_req_t   mem_req,
    output mem_bus_pkg::mem_rsp_t   mem_rsp,
    output logic [15:0]             prescale,
    output logic [7:0]              tx_data,
    output logic                    tx_valid,
    input  logic                    tx_ready,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid,
    output logic                    rx_ack,
    output logic                    clear_errors,
    input  uart_pkg::uart_status_t  status
);

    logic        rsp_ready;
    logic        ready_q;
    logic [31:0] rsp_rdata;

    // ------------------------------
    // Address decode
    // ------------------------------
    // Window match on bits 31..16
    wire hit      = (mem_req.addr[31:16] == {`UART_BASE_ADDR, 8'h00});
    wire is_write = |mem_req.wstrb;
    // Skip the ready cycle and the one after it
    wire serve    = mem_req.valid && hit && !rsp_ready && !ready_q;
    // Offsets outside the map fall to the default branches
    wire mem_bus_pkg::uart_reg_e offset = mem_bus_pkg::uart_reg_e'(mem_req.addr[3:0]);
    // Low byte written to TX with the transmitter free
    wire tx_accept = serve && is_write && (offset == mem_bus_pkg::REG_TX)
                     && mem_req.wstrb[0] && tx_ready;

    // ------------------------------
    // Bus handling
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_ready    <= 1'b0;
            ready_q      <= 1'b0;
            rsp_rdata    <= '0;
            tx_valid     <= 1'b0;
            rx_ack       <= 1'b0;
            clear_errors <= 1'b0;
            prescale     <= `UART_PRESCALE_RESET;
        end else begin
            // Single-cycle pulses by default
            rsp_ready    <= 1'b0;
            rsp_rdata    <= '0;
            tx_valid     <= 1'b0;
            rx_ack       <= 1'b0;
            clear_errors <= 1'b0;
            ready_q      <= rsp_ready;
            if (serve) begin
                rsp_ready <= 1'b1;
                if (is_write) begin
                    case (offset)
                        mem_bus_pkg::REG_TX: begin
                            if (mem_req.wstrb[0]) begin
                                if (tx_ready) begin
                                    tx_valid <= 1'b1;
                                end else begin
                                    // Hold off ready, retried next cycle
                                    rsp_ready <= 1'b0;
                                end
                            end
                        end
                        mem_bus_pkg::REG_BAUD: begin
                            if (mem_req.wstrb[0]) prescale[7:0]  <= mem_req.wdata[7:0];
                            if (mem_req.wstrb[1]) prescale[15:8] <= mem_req.wdata[15:8];
                        end
                        default: begin
                        end
                    endcase
                end else begin
                    case (offset)
                        mem_bus_pkg::REG_STATUS: begin
                            // Reading status clears the sticky flags
                            rsp_rdata    <= {28'd0, status};
                            clear_errors <= 1'b1;
                        end
                        mem_bus_pkg::REG_RX: begin
                            if (rx_valid) begin
                                rsp_rdata <= {24'd0, rx_data};
                                rx_ack    <= 1'b1;
                            end else begin
                                rsp_rdata <= `UART_RX_EMPTY;
                            end
                        end
                        default: begin
                            rsp_rdata <= '0;
                        end
                    endcase
                end
            end
        end
    end

    // TX byte register
    always_ff @(posedge clk) begin
        if (tx_accept) tx_data <= mem_req.wdata[7:0];
    end

    assign mem_rsp = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

// File: uart/uart_rx.sv
/*
 * UART receiver
 * Centers on the start bit, samples 8 data bits mid-bit and checks the stop bit
 * Holds the byte until rx_ack, with sticky overrun and frame error flags
 */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rxd,
    input  logic [15:0] prescale,
    output logic [7:0]  rx_data,
    output logic        rx_valid,
    input  logic        rx_ack,
    input  logic        clear_errors,
    output logic        busy,
    output logic        overrun,
    output logic        frame_err
);

    uart_pkg::rx_state_e state;
    logic                rxd_meta;
    logic                rxd_sync;
    logic [18:0]         div_cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift;

    wire [18:0] bit_period  = {prescale, 3'b000};
    wire [18:0] half_period = {1'b0, prescale, 2'b00};
    wire        bit_end     = (div_cnt == 19'd0);
    wire        last_bit    = (bit_idx == 3'(`UART_DATA_BITS - 1));
    // Stop bit center reached with the line high
    wire        byte_done   = (state == uart_pkg::RX_STOP) && bit_end && rxd_sync;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta  <= 1'b1;
            rxd_sync  <= 1'b1;
            state     <= uart_pkg::RX_IDLE;
            div_cnt   <= '0;
            bit_idx   <= '0;
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            // Two-flop synchronizer
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            if (!bit_end) div_cnt <= div_cnt - 19'd1;
            if (clear_errors) begin
                overrun   <= 1'b0;
                frame_err <= 1'b0;
            end
            if (rx_ack) rx_valid <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    // Falling edge, wait half a bit
                    if (!rxd_sync) begin
                        div_cnt <= half_period - 19'd1;
                        state   <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    if (bit_end) begin
                        bit_idx <= '0;
                        div_cnt <= bit_period - 19'd1;
                        // A high line here was a glitch
                        state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        div_cnt <= bit_period - 19'd1;
                        bit_idx <= bit_idx + 3'd1;
                        if (last_bit) state <= uart_pkg::RX_STOP;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= uart_pkg::RX_IDLE;
                        if (!rxd_sync) frame_err <= 1'b1;
                        if (byte_done) rx_valid <= 1'b1;
                        if (byte_done && rx_valid && !rx_ack) overrun <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && bit_end) shift <= {rxd_sync, shift[7:1]};
        if (byte_done) rx_data <= shift;
    end

    assign busy = (state != uart_pkg::RX_IDLE);

endmodule

// File: uart/uart_tx.sv
/*
 * UART transmitter
 * Sends one byte per tx_valid pulse, start bit, 8 data bits LSB first, stop bit
 * Each bit lasts prescale x 8 clocks
 */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  tx_data,
    input  logic        tx_valid,
    output logic        tx_ready,
    input  logic [15:0] prescale,
    output logic        txd,
    output logic        busy
);

    uart_pkg::tx_state_e state;
    logic [18:0]         div_cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift;

    // Clocks per bit
    wire [18:0] bit_period = {prescale, 3'b000};
    wire        bit_end    = (div_cnt == 19'd0);
    wire        last_bit   = (bit_idx == 3'(`UART_DATA_BITS - 1));

    // ------------------------------
    // Frame sequencer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= uart_pkg::TX_IDLE;
            txd     <= 1'b1;
            div_cnt <= '0;
            bit_idx <= '0;
        end else begin
            // Divider runs down, reloaded at each bit edge
            if (!bit_end) div_cnt <= div_cnt - 19'd1;
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (tx_valid) begin
                        // Start bit goes out on the next cycle
                        txd     <= 1'b0;
                        div_cnt <= bit_period - 19'd1;
                        state   <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        txd     <= shift[0];
                        bit_idx <= '0;
                        div_cnt <= bit_period - 19'd1;
                        state   <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        div_cnt <= bit_period - 19'd1;
                        if (last_bit) begin
                            // Stop bit, line high
                            txd   <= 1'b1;
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            txd     <= shift[0];
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                default: begin
                    if (bit_end) state <= uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Byte latched on accept, shifted right as each data bit leaves
    always_ff @(posedge clk) begin
        if (state == uart_pkg::TX_IDLE && tx_valid) begin
            shift <= tx_data;
        end else if (bit_end && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    assign tx_ready = (state == uart_pkg::TX_IDLE);
    assign busy     = (state != uart_pkg::TX_IDLE);

endmodule

// File: common/uart_pkg.sv
/*
 * UART engine types
 * Status word layout and the TX and RX state machines
 */
package uart_pkg;

    // ------------------------------
    // Status register, bits 3..0
    // ------------------------------
    typedef struct packed {
        // Stop bit sampled low, sticky
        logic frame_err;
        // Byte completed while the last one was unread, sticky
        logic overrun;
        logic rx_busy;
        logic tx_busy;
    } uart_status_t;

    // ------------------------------
    // Engine states
    // ------------------------------
    // Transmitter
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Receiver
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// File: common/mem_bus_pkg.sv
/*
 * Memory bus types
 * Packed request and response words of the core bus and the UART register map
 */
package mem_bus_pkg;

    // ------------------------------
    // Request, master to peripheral
    // ------------------------------
    // Nonzero wstrb marks a write, zero a read
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    // ------------------------------
    // Response, peripheral to master
    // ------------------------------
    // ready is a single-cycle pulse
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } mem_rsp_t;

    // Byte offsets of the word registers inside the window
    typedef enum logic [3:0] {
        REG_TX     = 4'h0,
        REG_STATUS = 4'h4,
        REG_RX     = 4'h8,
        REG_BAUD   = 4'hC
    } uart_reg_e;

endpackage

// File: common/uart_defines.svh
/*
 * UART peripheral constants
 * Bus window base, frame width, prescale reset value and the RX empty marker
 */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Upper address byte of the 64 KiB window, bits 23..16 stay zero
`define UART_BASE_ADDR 8'h02

// Data bits per frame
`define UART_DATA_BITS 8

// Prescale after reset, 8 clocks per bit
`define UART_PRESCALE_RESET 16'd1

// Returned by an RX read with no byte waiting
`define UART_RX_EMPTY 32'hFFFF_FF00

`endif
